// ==== common/tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

    // table geometry
    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = 4;

    // field widths
    localparam int vpn2_w = 19;
    localparam int asid_w = 10;
    localparam int ps_w   = 6;
    localparam int pfn_w  = 20;
    localparam int exc_w  = 7;

    // page size codes as stored in the ps field
    localparam logic [ps_w-1:0] ps_4k = 6'd12;
    localparam logic [ps_w-1:0] ps_2m = 6'd21;

    // one entry maps an even/odd page pair
    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic [asid_w-1:0] asid;
        logic [ps_w-1:0]   ps;
        logic              e;
        logic              g;
        logic [pfn_w-1:0]  pfn0;
        logic [1:0]        mat0;
        logic [1:0]        plv0;
        logic              d0;
        logic              v0;
        logic [pfn_w-1:0]  pfn1;
        logic [1:0]        mat1;
        logic [1:0]        plv1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        mem_fetch = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_type_e;

    typedef enum logic [1:0] {
        mode_direct = 2'd0,
        mode_mapped = 2'd1
    } trans_mode_e;

    // bit positions in the exception vector
    typedef enum logic [2:0] {
        exc_tlbr = 3'd0,
        exc_pif  = 3'd1,
        exc_pil  = 3'd2,
        exc_pis  = 3'd3,
        exc_ppi  = 3'd4,
        exc_pme  = 3'd5,
        exc_ade  = 3'd6
    } exc_bit_e;

    typedef enum logic [2:0] {
        inv_all0     = 3'd0,
        inv_all1     = 3'd1,
        inv_glob     = 3'd2,
        inv_nglob    = 3'd3,
        inv_asid     = 3'd4,
        inv_asid_va  = 3'd5,
        inv_gasid_va = 3'd6
    } invtlb_op_e;

    // 2m pages ignore the low vpn2 bits
    function automatic logic entry_hits(
        input tlb_entry_t        ent,
        input logic [vpn2_w-1:0] vpn2,
        input logic [asid_w-1:0] asid
    );
        logic asid_ok;
        logic vpn_ok;
        asid_ok = ent.g || (ent.asid == asid);
        if (ent.ps == ps_2m) begin
            vpn_ok = (ent.vpn2[18:9] == vpn2[18:9]);
        end else begin
            vpn_ok = (ent.vpn2 == vpn2);
        end
        return ent.e && asid_ok && vpn_ok;
    endfunction

endpackage

`default_nettype wire

// ==== common/tlb_write_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface tlb_write_if import tlb_pkg::*; ();

    logic                 we;
    logic [tlb_idx_w-1:0] w_index;
    tlb_entry_t           w_entry;

    // invalidate command
    logic                 inv_en;
    invtlb_op_e           inv_op;
    logic [asid_w-1:0]    inv_asid;
    logic [31:0]          inv_vaddr;

    modport src (
        output we, w_index, w_entry,
        output inv_en, inv_op, inv_asid, inv_vaddr
    );

    modport mem (
        input we, w_index, w_entry,
        input inv_en, inv_op, inv_asid, inv_vaddr
    );

endinterface

`default_nettype wire

// ==== tlb/tlb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_memory import tlb_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,

    tlb_write_if.mem               wr,

    input  wire logic [tlb_idx_w-1:0] r_index,
    output tlb_entry_t             r_entry,

    input  wire logic [vpn2_w-1:0] s_vpn2,
    input  wire logic [asid_w-1:0] s_asid,
    output logic [tlb_idx_w-1:0]   s_index,
    output logic                   s_hit,

    output tlb_entry_t             entries [tlb_num]
);

    tlb_entry_t          table_q [tlb_num];

    logic [tlb_num-1:0]  va_hit;
    logic [tlb_num-1:0]  asid_eq;
    logic [tlb_num-1:0]  inv_sel;
    logic [tlb_num-1:0]  probe_hit;

    // per-entry invalidate select and probe match
    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            va_hit[i]    = entry_hits(table_q[i], wr.inv_vaddr[31:13], wr.inv_asid);
            asid_eq[i]   = (table_q[i].asid == wr.inv_asid);
            probe_hit[i] = entry_hits(table_q[i], s_vpn2, s_asid);
            case (wr.inv_op)
                inv_all0,
                inv_all1:     inv_sel[i] = 1'b1;
                inv_glob:     inv_sel[i] = table_q[i].g;
                inv_nglob:    inv_sel[i] = !table_q[i].g;
                inv_asid:     inv_sel[i] = !table_q[i].g && asid_eq[i];
                // va_hit already requires the asid for non-global entries
                inv_asid_va:  inv_sel[i] = !table_q[i].g && va_hit[i];
                inv_gasid_va: inv_sel[i] = va_hit[i];
                default:      inv_sel[i] = 1'b0;
            endcase
        end
    end

    // invalidate first, then the write, so a written entry survives
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tlb_num; i++) begin
                table_q[i].e <= 1'b0;
            end
        end else begin
            if (wr.inv_en) begin
                for (int i = 0; i < tlb_num; i++) begin
                    if (inv_sel[i]) begin
                        table_q[i].e <= 1'b0;
                    end
                end
            end
            if (wr.we) begin
                table_q[wr.w_index] <= wr.w_entry;
            end
        end
    end

    // lowest matching index wins
    always_comb begin
        s_index = '0;
        s_hit   = 1'b0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (probe_hit[i]) begin
                s_index = tlb_idx_w'(i);
                s_hit   = 1'b1;
            end
        end
    end

    assign r_entry = table_q[r_index];
    assign entries = table_q;

endmodule

`default_nettype wire

// ==== tlb/tlb_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup import tlb_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              en,
    input  wire logic [31:0]       vaddr,
    input  wire logic [asid_w-1:0] asid,
    input  wire logic [1:0]        plv,
    input  wire mem_type_e         mem_type,

    input  wire trans_mode_e       mode,
    input  wire tlb_entry_t        entries [tlb_num],

    output logic [31:0]            paddr,
    output logic [exc_w-1:0]       exception
);

    logic [31:0]       vaddr_q;
    logic [asid_w-1:0] asid_q;
    logic [1:0]        plv_q;
    mem_type_e         mem_type_q;

    logic              hit;
    tlb_entry_t        sel_entry;
    logic              is_2m;
    logic              odd;

    logic [pfn_w-1:0]  pg_pfn;
    logic [1:0]        pg_plv;
    logic              pg_d;
    logic              pg_v;

    // request held until the next strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            vaddr_q    <= '0;
            asid_q     <= '0;
            plv_q      <= '0;
            mem_type_q <= mem_fetch;
        end else if (en) begin
            vaddr_q    <= vaddr;
            asid_q     <= asid;
            plv_q      <= plv;
            mem_type_q <= mem_type;
        end
    end

    // entries are unique, lowest index taken anyway
    always_comb begin
        hit       = 1'b0;
        sel_entry = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (entry_hits(entries[i], vaddr_q[31:13], asid_q)) begin
                hit       = 1'b1;
                sel_entry = entries[i];
            end
        end
    end

    // even/odd half select
    assign is_2m = (sel_entry.ps == ps_2m);
    assign odd   = is_2m ? vaddr_q[21] : vaddr_q[12];

    assign pg_pfn = odd ? sel_entry.pfn1 : sel_entry.pfn0;
    assign pg_plv = odd ? sel_entry.plv1 : sel_entry.plv0;
    assign pg_d   = odd ? sel_entry.d1   : sel_entry.d0;
    assign pg_v   = odd ? sel_entry.v1   : sel_entry.v0;

    always_comb begin
        if (mode != mode_mapped) begin
            paddr = vaddr_q;
        end else if (is_2m) begin
            paddr = {pg_pfn[19:9], vaddr_q[20:0]};
        end else begin
            paddr = {pg_pfn, vaddr_q[11:0]};
        end
    end

    // one exception at most, highest priority first
    always_comb begin
        exception = '0;
        if (mode == mode_mapped) begin
            if (plv_q == 2'd3 && vaddr_q[31]) begin
                exception[exc_ade] = 1'b1;
            end else if (!hit) begin
                exception[exc_tlbr] = 1'b1;
            end else if (!pg_v) begin
                case (mem_type_q)
                    mem_fetch: exception[exc_pif] = 1'b1;
                    mem_store: exception[exc_pis] = 1'b1;
                    default:   exception[exc_pil] = 1'b1;
                endcase
            end else if (plv_q > pg_plv) begin
                exception[exc_ppi] = 1'b1;
            end else if (mem_type_q == mem_store && !pg_d) begin
                exception[exc_pme] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/tlb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_top import tlb_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire logic [1:0]           ad_mode,

    // fetch port
    input  wire logic [31:0]          s0_vaddr,
    input  wire logic [asid_w-1:0]    s0_asid,
    input  wire logic [1:0]           s0_plv,
    input  wire logic [1:0]           s0_mem_type,
    input  wire logic                 s0_en,
    output logic [31:0]               s0_paddr,
    output logic [exc_w-1:0]          s0_exception,

    // data port
    input  wire logic [31:0]          s1_vaddr,
    input  wire logic [asid_w-1:0]    s1_asid,
    input  wire logic [1:0]           s1_plv,
    input  wire logic [1:0]           s1_mem_type,
    input  wire logic                 s1_en,
    output logic [31:0]               s1_paddr,
    output logic [exc_w-1:0]          s1_exception,

    input  wire logic                 we,
    input  wire logic                 fill_mode,
    input  wire logic [tlb_idx_w-1:0] w_index,
    input  wire logic [tlb_idx_w-1:0] f_index,
    input  wire logic [vpn2_w-1:0]    w_vpn2,
    input  wire logic [asid_w-1:0]    w_asid,
    input  wire logic [ps_w-1:0]      w_ps,
    input  wire logic                 w_e,
    input  wire logic                 w_g,
    input  wire logic [pfn_w-1:0]     w_pfn0,
    input  wire logic [1:0]           w_mat0,
    input  wire logic [1:0]           w_plv0,
    input  wire logic                 w_d0,
    input  wire logic                 w_v0,
    input  wire logic [pfn_w-1:0]     w_pfn1,
    input  wire logic [1:0]           w_mat1,
    input  wire logic [1:0]           w_plv1,
    input  wire logic                 w_d1,
    input  wire logic                 w_v1,

    input  wire logic [tlb_idx_w-1:0] r_index,
    input  wire logic                 check_mode,
    output logic [vpn2_w-1:0]         r_vpn2,
    output logic [asid_w-1:0]         r_asid,
    output logic [ps_w-1:0]           r_ps,
    output logic                      r_g,
    output logic [pfn_w-1:0]          r_pfn0,
    output logic [1:0]                r_mat0,
    output logic [1:0]                r_plv0,
    output logic                      r_d0,
    output logic                      r_v0,
    output logic [pfn_w-1:0]          r_pfn1,
    output logic [1:0]                r_mat1,
    output logic [1:0]                r_plv1,
    output logic                      r_d1,
    output logic                      r_v1,

    input  wire logic [vpn2_w-1:0]    s_vpn2,
    input  wire logic [asid_w-1:0]    s_asid,
    output logic [tlb_idx_w-1:0]      s_index,
    output logic                      rs_e,

    input  wire logic                 clear_en,
    input  wire logic [2:0]           clear_mem,
    input  wire logic [31:0]          clear_vaddr,
    input  wire logic [asid_w-1:0]    clear_asid
);

    tlb_write_if wr_if ();

    tlb_entry_t  w_entry;
    tlb_entry_t  r_entry;
    tlb_entry_t  entries [tlb_num];
    trans_mode_e mode_q;
    logic        s_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q <= mode_direct;
        end else begin
            mode_q <= trans_mode_e'(ad_mode);
        end
    end

    assign w_entry = '{vpn2: w_vpn2, asid: w_asid, ps: w_ps, e: w_e, g: w_g,
                       pfn0: w_pfn0, mat0: w_mat0, plv0: w_plv0, d0: w_d0, v0: w_v0,
                       pfn1: w_pfn1, mat1: w_mat1, plv1: w_plv1, d1: w_d1, v1: w_v1};

    // fill index comes from the core when fill_mode is set
    assign wr_if.we        = we;
    assign wr_if.w_index   = fill_mode ? f_index : w_index;
    assign wr_if.w_entry   = w_entry;
    assign wr_if.inv_en    = clear_en;
    assign wr_if.inv_op    = invtlb_op_e'(clear_mem);
    assign wr_if.inv_asid  = clear_asid;
    assign wr_if.inv_vaddr = clear_vaddr;

    tlb_memory u_memory (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr_if),
        .r_index (r_index),
        .r_entry (r_entry),
        .s_vpn2  (s_vpn2),
        .s_asid  (s_asid),
        .s_index (s_index),
        .s_hit   (s_hit),
        .entries (entries)
    );

    tlb_lookup u_lookup0 (
        .clk       (clk),
        .rst       (rst),
        .en        (s0_en),
        .vaddr     (s0_vaddr),
        .asid      (s0_asid),
        .plv       (s0_plv),
        .mem_type  (mem_type_e'(s0_mem_type)),
        .mode      (mode_q),
        .entries   (entries),
        .paddr     (s0_paddr),
        .exception (s0_exception)
    );

    tlb_lookup u_lookup1 (
        .clk       (clk),
        .rst       (rst),
        .en        (s1_en),
        .vaddr     (s1_vaddr),
        .asid      (s1_asid),
        .plv       (s1_plv),
        .mem_type  (mem_type_e'(s1_mem_type)),
        .mode      (mode_q),
        .entries   (entries),
        .paddr     (s1_paddr),
        .exception (s1_exception)
    );

    // probe hit or read-entry e
    assign rs_e = check_mode ? s_hit : r_entry.e;

    assign r_vpn2 = r_entry.vpn2;
    assign r_asid = r_entry.asid;
    assign r_ps   = r_entry.ps;
    assign r_g    = r_entry.g;
    assign r_pfn0 = r_entry.pfn0;
    assign r_mat0 = r_entry.mat0;
    assign r_plv0 = r_entry.plv0;
    assign r_d0   = r_entry.d0;
    assign r_v0   = r_entry.v0;
    assign r_pfn1 = r_entry.pfn1;
    assign r_mat1 = r_entry.mat1;
    assign r_plv1 = r_entry.plv1;
    assign r_d1   = r_entry.d1;
    assign r_v1   = r_entry.v1;

endmodule

`default_nettype wire

// ==== dv/tlb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_tb;

    logic        clk;
    logic        rst;
    logic [1:0]  ad_mode;

    // lookup ports
    logic [31:0] s0_vaddr, s1_vaddr, s0_paddr, s1_paddr;
    logic [9:0]  s0_asid, s1_asid;
    logic [1:0]  s0_plv, s1_plv, s0_mem_type, s1_mem_type;
    logic        s0_en, s1_en;
    logic [6:0]  s0_exception, s1_exception;

    // write, read, probe and invalidate ports
    logic        we, fill_mode, w_e, w_g, w_d0, w_v0, w_d1, w_v1;
    logic [3:0]  w_index, f_index, r_index, s_index;
    logic [18:0] w_vpn2, r_vpn2, s_vpn2;
    logic [9:0]  w_asid, r_asid, s_asid, clear_asid;
    logic [5:0]  w_ps, r_ps;
    logic [19:0] w_pfn0, w_pfn1, r_pfn0, r_pfn1;
    logic [1:0]  w_mat0, w_plv0, w_mat1, w_plv1, r_mat0, r_plv0, r_mat1, r_plv1;
    logic        check_mode, r_g, r_d0, r_v0, r_d1, r_v1, rs_e;
    logic        clear_en;
    logic [2:0]  clear_mem;
    logic [31:0] clear_vaddr;

    string       lines [$];
    string       name;
    string       cmd;
    logic [31:0] op [10];
    int          errs;
    int          n_pass;
    int          n_fail;
    bit          loaded;

    tlb_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_value(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERR %s %s expected %h actual %h", name, what, exp, got);
            errs++;
        end
    endtask

    // eg packs {e, g}, attr packs {mat, plv, d, v}
    task automatic write_entry();
        next_cycle();
        we        = 1'b1;
        fill_mode = op[0][0];
        // the unused index points elsewhere
        w_index   = op[0][0] ? ~op[1][3:0] : op[1][3:0];
        f_index   = op[0][0] ? op[1][3:0] : ~op[1][3:0];
        {w_vpn2, w_asid, w_ps} = {op[2][18:0], op[3][9:0], op[4][5:0]};
        {w_e, w_g} = op[5][1:0];
        {w_pfn0, w_mat0, w_plv0, w_d0, w_v0} = {op[6][19:0], op[7][5:0]};
        {w_pfn1, w_mat1, w_plv1, w_d1, w_v1} = {op[8][19:0], op[9][5:0]};
        next_cycle();
        we = 1'b0;
    endtask

    task automatic read_back();
        next_cycle();
        r_index    = op[0][3:0];
        check_mode = 1'b0;
        @(negedge clk);
        compare_value("vpn2", op[1], 32'(r_vpn2));
        compare_value("asid", op[2], 32'(r_asid));
        compare_value("ps", op[3], 32'(r_ps));
        compare_value("e_g", op[4], 32'({rs_e, r_g}));
        compare_value("pfn0", op[5], 32'(r_pfn0));
        compare_value("attr0", op[6], 32'({r_mat0, r_plv0, r_d0, r_v0}));
        compare_value("pfn1", op[7], 32'(r_pfn1));
        compare_value("attr1", op[8], 32'({r_mat1, r_plv1, r_d1, r_v1}));
    endtask

    // both ports see the request, only the chosen one is strobed
    task automatic translate();
        logic [31:0] got_paddr;
        logic [6:0]  got_exc;
        next_cycle();
        {s0_vaddr, s0_asid, s0_plv, s0_mem_type} = {op[2], op[3][9:0], op[4][1:0], op[5][1:0]};
        {s1_vaddr, s1_asid, s1_plv, s1_mem_type} = {op[2], op[3][9:0], op[4][1:0], op[5][1:0]};
        s0_en = (op[0] == 32'd0) && op[1][0];
        s1_en = (op[0] != 32'd0) && op[1][0];
        next_cycle();
        s0_en = 1'b0;
        s1_en = 1'b0;
        @(negedge clk);
        got_paddr = (op[0] == 32'd0) ? s0_paddr : s1_paddr;
        got_exc   = (op[0] == 32'd0) ? s0_exception : s1_exception;
        // no address is defined when an exception is raised
        if (op[7] == 32'd0) begin
            compare_value("paddr", op[6], got_paddr);
        end
        compare_value("exception", op[7], 32'(got_exc));
    endtask

    task automatic probe_table();
        next_cycle();
        s_vpn2     = op[0][18:0];
        s_asid     = op[1][9:0];
        check_mode = 1'b1;
        @(negedge clk);
        compare_value("hit", op[2], 32'(rs_e));
        if (op[2][0]) begin
            compare_value("index", op[3], 32'(s_index));
        end
    endtask

    task automatic invalidate();
        next_cycle();
        clear_en    = 1'b1;
        clear_mem   = op[0][2:0];
        clear_asid  = op[1][9:0];
        clear_vaddr = op[2];
        next_cycle();
        clear_en = 1'b0;
    endtask

    task automatic set_mode();
        next_cycle();
        ad_mode = op[0][1:0];
        next_cycle();
    endtask

    initial begin
        int    fd;
        string line;
        rst = 1'b1;
        {ad_mode, we, fill_mode, w_index, f_index, r_index, check_mode} = '0;
        {s0_vaddr, s0_asid, s0_plv, s0_mem_type, s0_en} = '0;
        {s1_vaddr, s1_asid, s1_plv, s1_mem_type, s1_en} = '0;
        {w_vpn2, w_asid, w_ps, w_e, w_g} = '0;
        {w_pfn0, w_mat0, w_plv0, w_d0, w_v0, w_pfn1, w_mat1, w_plv1, w_d1, w_v1} = '0;
        {s_vpn2, s_asid, clear_en, clear_mem, clear_vaddr, clear_asid} = '0;
        n_pass = 0;
        n_fail = 0;
        fd = $fopen("dv/tlb_input.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end else begin
            $display("could not open the stimulus file dv/tlb_input.txt");
            n_fail++;
        end
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (lines[i]) begin
            for (int k = 0; k < 10; k++) begin
                op[k] = '0;
            end
            errs = 0;
            void'($sscanf(lines[i], "%s %s %h %h %h %h %h %h %h %h %h %h", name, cmd,
                          op[0], op[1], op[2], op[3], op[4], op[5], op[6], op[7], op[8], op[9]));
            case (cmd)
                "write":  write_entry();
                "read":   read_back();
                "lookup": translate();
                "probe":  probe_table();
                "inval":  invalidate();
                "mode":   set_mode();
                default: begin
                    $display("test %s has an unknown command %s", name, cmd);
                    errs++;
                end
            endcase
            if (errs == 0) begin
                $display("%-16s ok", name);
                n_pass++;
            end else begin
                $display("%-16s failed", name);
                n_fail++;
            end
        end
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // run length grows with the number of stimulus lines
    initial begin
        wait (loaded);
        repeat (lines.size() * 4 + 20) @(posedge clk);
        $display("timeout: the test sequence did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tlb_input.txt ====
# name cmd, then hex: write fill idx vpn2 asid ps eg pfn0 at0 pfn1 at1 | read idx + same fields
# lookup port en va asid plv type pa exc | probe vpn2 asid hit idx | inval op asid va | mode m
rst_hold      lookup 0 0 deadbeef 000 0 0 00000000 00
direct_p1     lookup 1 1 12345678 000 0 1 12345678 00
wr_a          write  0 1 00012 005 0c 2 11111 1f 22222 21
wr_b_fill     write  1 9 20000 007 15 3 80000 0f 80200 1f
wr_c          write  0 4 00040 005 0c 2 33333 00 44444 03
wr_d          write  0 6 00080 009 0c 2 55555 0d 66666 0d
rd_a          read   1 00012 005 0c 2 11111 1f 22222 21
rd_b_fill     read   9 20000 007 15 3 80000 0f 80200 1f
map_on        mode   1
map_4k_even   lookup 0 1 00024abc 005 0 0 11111abc 00
map_4k_odd    lookup 1 1 00025123 005 0 1 22222123 00
hold_p0       lookup 0 0 00300000 005 0 0 11111abc 00
map_2m_glob   lookup 1 1 40012345 3ff 3 2 80012345 00
map_2m_odd    lookup 0 1 40200010 001 0 0 80200010 00
miss_asid     lookup 1 1 00024000 006 0 1 00000000 01
exc_pif       lookup 0 1 00080000 005 0 0 00000000 02
exc_pil       lookup 1 1 00080004 005 0 1 00000000 04
exc_pis       lookup 1 1 00080008 005 0 2 00000000 08
exc_ppi       lookup 1 1 00081abc 005 3 1 00000000 10
map_c_odd     lookup 0 1 00081abc 005 0 2 44444abc 00
exc_pme       lookup 1 1 00100040 009 0 2 00000000 20
exc_ade       lookup 0 1 80000000 005 3 0 00000000 40
probe_a       probe  00012 005 1 1
probe_b_glob  probe  20005 123 1 9
probe_miss    probe  00012 006 0 0
inv_asid_va   inval  5 005 00080000
probe_c_gone  probe  00040 005 0 0
inv_asid      inval  4 009 00000000
lookup_d_gone lookup 1 1 00100040 009 0 1 00000000 01
inv_glob      inval  2 000 00000000
lookup_b_gone lookup 0 1 40012345 3ff 0 0 00000000 01
probe_a_kept  probe  00012 005 1 1
inv_gasid_va  inval  6 005 00024000
probe_a_gone  probe  00012 005 0 0
rewr_a        write  0 1 00012 005 0c 2 11111 1f 22222 21
rewr_b        write  1 9 20000 007 15 3 80000 0f 80200 1f
inv_nglob     inval  3 000 00000000
probe_b_kept  probe  20000 000 1 9
probe_a_ng    probe  00012 005 0 0
inv_all1      inval  1 000 00000000
probe_b_all   probe  20000 000 0 0
map_off       mode   0
direct_ade    lookup 1 1 80001234 005 3 0 80001234 00

// ==== sim.f ====
common/tlb_pkg.sv
common/tlb_write_if.sv
tlb/tlb_memory.sv
tlb/tlb_lookup.sv
design/tlb_top.sv
dv/tlb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run from the project root, then scan the log
verilator --binary --timing --assert -f sim.f --top-module tlb_tb -o tlb_sim \
    && ./obj_dir/tlb_sim > sim.log 2>&1 \
    || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
